/* rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// datapath geometry, fixed by RV32I
`define RV_XLEN      32
`define RV_REG_COUNT 32

`define RV_RESET_PC  32'h0000_0000 // first fetch address

// special instruction words
`define RV_NOP       32'h0000_0013 // addi x0, x0, 0
`define RV_WFI       32'h1050_0073 // wait for interrupt, used as halt

// major opcodes, bits [6:0]
`define RV_OP_REG    7'b011_0011 // add, sub
`define RV_OP_IMM    7'b001_0011 // addi
`define RV_OP_LOAD   7'b000_0011 // lw
`define RV_OP_STORE  7'b010_0011 // sw
`define RV_OP_BRANCH 7'b110_0011 // beq
`define RV_OP_SYSTEM 7'b111_0011 // wfi

`endif

/* rv_pkg.sv */
`default_nettype none

`include "rv_cfg.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]               word_t;
    typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_idx_t;

    //////////////////////////////////////////////////////////////////////
    // instruction word, one union with a view per format
    //////////////////////////////////////////////////////////////////////

    typedef union packed {
        struct packed {
            logic [6:0] funct7;  // bit 5 picks sub
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            reg_idx_t   rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            reg_idx_t    rs1;
            logic [2:0]  funct3;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;  // imm[11:5]
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;  // imm[4:0]
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;  // odd one out, sits where rd would be
            logic [6:0] opcode;
        } b;
    } rv_inst_t;

    typedef enum logic {
        alu_add,
        alu_sub
    } alu_func_t;

    // same encoding as the memory bus
    typedef enum logic [1:0] {
        bus_none  = 2'b00,
        bus_load  = 2'b01,
        bus_store = 2'b10
    } bus_cmd_t;

    //////////////////////////////////////////////////////////////////////
    // stage packets
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        word_t    pc;
        rv_inst_t inst;
        logic     valid;
    } if_id_t;

    typedef struct packed {
        word_t     pc;
        rv_inst_t  inst;
        word_t     rs1_value; // already forwarded
        word_t     rs2_value;
        word_t     imm;       // sign extended for the format
        reg_idx_t  dest;      // 0 when nothing is written
        alu_func_t alu_func;
        logic      use_imm;
        logic      rd_mem;
        logic      wr_mem;
        logic      branch;
        logic      halt;
        logic      valid;
    } id_ex_t;

    typedef struct packed {
        word_t    pc;
        word_t    alu_result; // also the memory address
        word_t    store_data;
        reg_idx_t dest;
        logic     rd_mem;
        logic     wr_mem;
        logic     halt;
        logic     valid;
    } ex_mem_t;

    typedef struct packed {
        word_t    pc;
        word_t    result;
        reg_idx_t dest;
        logic     wr_en;
        logic     halt;
        logic     valid;
    } mem_wb_t;

endpackage

`default_nettype wire

/* bypass_if.sv */
`timescale 1ns/1ps
`default_nettype none

// memory stage and writeback back into decode
interface bypass_if;
    import rv_pkg::*;

    reg_idx_t mem_dest;   // instruction now in MEM
    word_t    mem_value;  // load data straight off the bus
    logic     mem_fwd_en;

    logic     wb_en;      // register file write
    reg_idx_t wb_idx;
    word_t    wb_data;

    modport source (
        output mem_dest, mem_value, mem_fwd_en, wb_en, wb_idx, wb_data
    );
    modport sink (
        input  mem_dest, mem_value, mem_fwd_en, wb_en, wb_idx, wb_data
    );

endinterface

`default_nettype wire

/* fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module fetch_unit (
    input  logic            clock,
    input  logic            reset,
    input  logic            load_stall,    // hold pc and if/id
    input  logic            take_branch,   // redirect from execute
    input  rv_pkg::word_t   branch_target,
    input  logic            fetch_grant,   // bus is ours this cycle
    input  rv_pkg::word_t   fetch_inst,
    output rv_pkg::word_t   fetch_addr,
    output rv_pkg::if_id_t  if_id
);
    import rv_pkg::*;

    word_t pc;

    assign fetch_addr = pc; // always request, memory_access decides

    //////////////////////////////////////////////////////////////////////
    // pc and if/id register
    //////////////////////////////////////////////////////////////////////

    // priority: redirect, stall, grant
    always_ff @(posedge clock) begin
        if (reset) begin
            pc          <= `RV_RESET_PC;
            if_id.valid <= 1'b0;
            if_id.inst  <= `RV_NOP;
        end else if (take_branch) begin
            pc          <= branch_target;
            if_id.valid <= 1'b0;        // squash whatever was fetched
            if_id.inst  <= `RV_NOP;
        end else if (!load_stall) begin
            if (fetch_grant) begin
                pc          <= pc + 32'd4;
                if_id.pc    <= pc;
                if_id.inst  <= fetch_inst;
                if_id.valid <= 1'b1;
            end else begin
                // data access won the bus, try again
                if_id.valid <= 1'b0;
                if_id.inst  <= `RV_NOP;
            end
        end
    end

endmodule

`default_nettype wire

/* decode_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module decode_unit (
    input  logic              clock,
    input  logic              reset,
    input  rv_pkg::if_id_t    if_id,
    input  logic              take_branch,
    input  logic              ex_fwd_en,   // alu result usable now
    input  rv_pkg::reg_idx_t  ex_dest,
    input  rv_pkg::word_t     ex_value,
    input  logic              ex_is_load,
    bypass_if.sink            bypass,
    output logic              load_stall,
    output rv_pkg::id_ex_t    id_ex
);
    import rv_pkg::*;

    word_t    regs [`RV_REG_COUNT];
    id_ex_t   decoded;
    rv_inst_t inst;
    reg_idx_t rs1;
    reg_idx_t rs2;

    assign inst = if_id.inst;
    assign rs1  = inst.r.rs1; // same place in every format
    assign rs2  = inst.r.rs2;

    // newest producer wins
    function automatic word_t operand(input reg_idx_t idx);
        if (idx == '0)                                 return '0;
        if (ex_fwd_en && ex_dest == idx)               return ex_value;
        if (bypass.mem_fwd_en && bypass.mem_dest == idx) return bypass.mem_value;
        if (bypass.wb_en && bypass.wb_idx == idx)      return bypass.wb_data;
        return regs[idx];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // decode and operand select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        decoded           = '0;
        decoded.pc        = if_id.pc;
        decoded.inst      = inst;
        decoded.valid     = if_id.valid;
        decoded.rs1_value = operand(rs1);
        decoded.rs2_value = operand(rs2);
        decoded.alu_func  = alu_add;
        case (inst.r.opcode)
            `RV_OP_REG: begin
                decoded.dest     = inst.r.rd;
                decoded.alu_func = inst.r.funct7[5] ? alu_sub : alu_add;
            end
            `RV_OP_IMM, `RV_OP_LOAD: begin
                decoded.dest    = inst.i.rd;
                decoded.imm     = {{20{inst.i.imm[11]}}, inst.i.imm};
                decoded.use_imm = 1'b1;
                decoded.rd_mem  = (inst.i.opcode == `RV_OP_LOAD);
            end
            `RV_OP_STORE: begin
                decoded.imm     = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
                decoded.use_imm = 1'b1; // address = rs1 + imm
                decoded.wr_mem  = 1'b1;
            end
            `RV_OP_BRANCH: begin
                decoded.imm    = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                                  inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
                decoded.branch = 1'b1;
            end
            `RV_OP_SYSTEM: decoded.halt = (inst == `RV_WFI);
            default: ;  // unsupported, undefined
        endcase
    end

    // load in ex, its data shows up one cycle too late
    assign load_stall = if_id.valid && ex_is_load && ex_dest != '0
                        && (ex_dest == rs1 || ex_dest == rs2);

    //////////////////////////////////////////////////////////////////////
    // register file and id/ex register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (bypass.wb_en && bypass.wb_idx != '0) begin
            regs[bypass.wb_idx] <= bypass.wb_data; // x0 stays unwritten
        end
    end

    always_ff @(posedge clock) begin
        if (reset || take_branch || load_stall) begin
            id_ex      <= '0;       // bubble
            id_ex.inst <= `RV_NOP;
        end else begin
            id_ex <= decoded;
        end
    end

endmodule

`default_nettype wire

/* execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  logic              clock,
    input  logic              reset,
    input  rv_pkg::id_ex_t    id_ex,
    output logic              ex_fwd_en,
    output rv_pkg::reg_idx_t  ex_dest,
    output rv_pkg::word_t     ex_value,
    output logic              ex_is_load,
    output logic              take_branch,
    output rv_pkg::word_t     branch_target,
    output rv_pkg::ex_mem_t   ex_mem
);
    import rv_pkg::*;

    word_t op_b;
    word_t alu_result;

    //////////////////////////////////////////////////////////////////////
    // alu and branch
    //////////////////////////////////////////////////////////////////////

    assign op_b       = id_ex.use_imm ? id_ex.imm : id_ex.rs2_value;
    assign alu_result = (id_ex.alu_func == alu_sub) ? id_ex.rs1_value - op_b
                                                    : id_ex.rs1_value + op_b;

    // beq only, resolved here
    assign take_branch   = id_ex.valid && id_ex.branch
                           && (id_ex.rs1_value == id_ex.rs2_value);
    assign branch_target = id_ex.pc + id_ex.imm; // imm holds the b offset

    // loads have no value yet, decode stalls for those
    assign ex_fwd_en  = id_ex.valid && id_ex.dest != '0 && !id_ex.rd_mem;
    assign ex_is_load = id_ex.valid && id_ex.rd_mem;
    assign ex_dest    = id_ex.dest;
    assign ex_value   = alu_result;

    //////////////////////////////////////////////////////////////////////
    // ex/mem register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem.pc         <= id_ex.pc;
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= id_ex.rs2_value;
            ex_mem.dest       <= id_ex.dest;     // 0 for branch and store
            ex_mem.rd_mem     <= id_ex.rd_mem;
            ex_mem.wr_mem     <= id_ex.wr_mem;
            ex_mem.halt       <= id_ex.halt;
            ex_mem.valid      <= id_ex.valid;
        end
    end

endmodule

`default_nettype wire

/* memory_access.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_access (
    input  logic              clock,
    input  logic              reset,
    input  rv_pkg::ex_mem_t   ex_mem,
    input  rv_pkg::word_t     fetch_addr,
    output logic              fetch_grant,
    output rv_pkg::word_t     fetch_inst,
    output rv_pkg::bus_cmd_t  mem_command,
    output rv_pkg::word_t     mem_addr,
    output rv_pkg::word_t     mem_wdata,
    input  rv_pkg::word_t     mem_rdata,
    bypass_if.source          bypass,
    output logic              commit_valid,
    output logic              commit_wr_en,
    output rv_pkg::reg_idx_t  commit_idx,
    output rv_pkg::word_t     commit_data,
    output rv_pkg::word_t     commit_pc,
    output logic              halted
);
    import rv_pkg::*;

    bus_cmd_t data_cmd;
    word_t    mem_result;
    mem_wb_t  mem_wb;
    logic     halted_q;  // wfi already committed

    //////////////////////////////////////////////////////////////////////
    // bus, data access ahead of fetch
    //////////////////////////////////////////////////////////////////////

    assign data_cmd = !ex_mem.valid ? bus_none  :
                      ex_mem.rd_mem ? bus_load  :
                      ex_mem.wr_mem ? bus_store : bus_none;

    assign fetch_grant = (data_cmd == bus_none);
    assign mem_command = fetch_grant ? bus_load   : data_cmd;
    assign mem_addr    = fetch_grant ? fetch_addr : ex_mem.alu_result;
    assign mem_wdata   = ex_mem.store_data;
    assign fetch_inst  = mem_rdata; // only looked at when granted

    assign mem_result = ex_mem.rd_mem ? mem_rdata : ex_mem.alu_result;

    assign bypass.mem_dest   = ex_mem.dest;
    assign bypass.mem_value  = mem_result;
    assign bypass.mem_fwd_en = ex_mem.valid && ex_mem.dest != '0;

    //////////////////////////////////////////////////////////////////////
    // mem/wb register, writeback, commit
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            mem_wb   <= '0;
            halted_q <= 1'b0;
        end else begin
            mem_wb.pc     <= ex_mem.pc;
            mem_wb.result <= mem_result;
            mem_wb.dest   <= ex_mem.dest;
            mem_wb.wr_en  <= ex_mem.dest != '0; // addi x0 commits without a write
            mem_wb.halt   <= ex_mem.halt;
            mem_wb.valid  <= ex_mem.valid;
            halted_q      <= halted;            // sticky
        end
    end

    assign halted       = halted_q || (mem_wb.valid && mem_wb.halt);
    assign commit_valid = mem_wb.valid && !halted_q; // wfi itself still commits
    assign commit_wr_en = commit_valid && mem_wb.wr_en;
    assign commit_idx   = mem_wb.dest;
    assign commit_data  = mem_wb.result;
    assign commit_pc    = mem_wb.pc;

    assign bypass.wb_en   = commit_wr_en;
    assign bypass.wb_idx  = mem_wb.dest;
    assign bypass.wb_data = mem_wb.result;

endmodule

`default_nettype wire

/* rv_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_pipeline (
    input  logic              clock,
    input  logic              reset,
    input  rv_pkg::word_t     mem_rdata,
    output rv_pkg::bus_cmd_t  mem_command,
    output rv_pkg::word_t     mem_addr,
    output rv_pkg::word_t     mem_wdata,
    output logic              commit_valid,
    output logic              commit_wr_en,
    output rv_pkg::reg_idx_t  commit_idx,
    output rv_pkg::word_t     commit_data,
    output rv_pkg::word_t     commit_pc,
    output logic              halted
);
    import rv_pkg::*;

    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    logic     load_stall;
    logic     take_branch;
    word_t    branch_target;
    word_t    fetch_addr;
    logic     fetch_grant;
    word_t    fetch_inst;
    logic     ex_fwd_en;   // execute result back to decode
    reg_idx_t ex_dest;
    word_t    ex_value;
    logic     ex_is_load;

    bypass_if bypass ();   // mem stage and writeback to decode

    fetch_unit i_fetch_unit (
        .clock, .reset, .load_stall, .take_branch, .branch_target,
        .fetch_grant, .fetch_inst, .fetch_addr, .if_id
    );

    decode_unit i_decode_unit (
        .clock, .reset, .if_id, .take_branch,
        .ex_fwd_en, .ex_dest, .ex_value, .ex_is_load,
        .bypass (bypass.sink),
        .load_stall, .id_ex
    );

    execute_unit i_execute_unit (
        .clock, .reset, .id_ex,
        .ex_fwd_en, .ex_dest, .ex_value, .ex_is_load,
        .take_branch, .branch_target, .ex_mem
    );

    memory_access i_memory_access (
        .clock, .reset, .ex_mem, .fetch_addr, .fetch_grant, .fetch_inst,
        .mem_command, .mem_addr, .mem_wdata, .mem_rdata,
        .bypass (bypass.source),
        .commit_valid, .commit_wr_en, .commit_idx, .commit_data, .commit_pc,
        .halted
    );

endmodule

`default_nettype wire

/* tb_memory.sv */
`timescale 1ns/1ps
`default_nettype none

// behavioral word memory on the dut bus
module tb_memory (
    input  logic             clock,
    input  rv_pkg::bus_cmd_t mem_command,
    input  rv_pkg::word_t    mem_addr,
    input  rv_pkg::word_t    mem_wdata,
    output rv_pkg::word_t    mem_rdata
);
    import rv_pkg::*;

    localparam int DEPTH = 256; // 1 KiB, upper address bits ignored

    word_t      words [DEPTH];
    logic [7:0] index;

    assign index = mem_addr[9:2]; // word aligned only

    // every word different, so a stray read shows up
    task automatic fill_pattern();
        for (int i = 0; i < DEPTH; i++) begin
            words[i] = 32'hd05a_0000 ^ (i * 32'h0001_0101);
        end
        mem_rdata = '0;
    endtask

    task automatic write_word(input word_t addr, input word_t data);
        words[addr[9:2]] = data;
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus side, serviced mid-cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (mem_command == bus_store) begin
            words[index] = mem_wdata;
        end
        mem_rdata = words[index]; // stable before the next rising edge
    end

endmodule

`default_nettype wire

/* tb_rv_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module tb_rv_pipeline;
    import rv_pkg::*;

    localparam int PROG_LEN   = 18;
    localparam int EXP_LEN    = 16;
    localparam int DATA_BASE  = 'h100;  // byte address of the data words
    localparam int TAIL       = 8;      // cycles watched after wfi
    localparam int MAX_CYCLES = 5 * PROG_LEN + 20;

    typedef struct packed {
        word_t    pc;
        logic     wr_en;
        reg_idx_t idx;
        word_t    data;
        logic     halt;  // marks the wfi
    } commit_entry_t;

    logic     clock;
    logic     reset;
    word_t    mem_rdata;
    bus_cmd_t mem_command;
    word_t    mem_addr;
    word_t    mem_wdata;
    logic     commit_valid;
    logic     commit_wr_en;
    reg_idx_t commit_idx;
    word_t    commit_data;
    word_t    commit_pc;
    logic     halted;

    word_t         program_words [PROG_LEN];
    commit_entry_t expected [EXP_LEN];
    int            n_expected;
    int            next;        // next expected commit
    int            cycles;
    int            tail;
    int            stores;
    int            data_loads;
    logic          wfi_done;

    rv_pipeline i_rv_pipeline (.*);

    tb_memory i_memory (.clock, .mem_command, .mem_addr, .mem_wdata, .mem_rdata);

    always #4 clock = ~clock; // 8 ns period

    //////////////////////////////////////////////////////////////////////
    // instruction encoders for the rv32i formats
    //////////////////////////////////////////////////////////////////////

    function automatic word_t r_format(input logic [6:0] funct7, input reg_idx_t rd,
                                       input reg_idx_t rs1, input reg_idx_t rs2);
        return {funct7, rs2, rs1, 3'b000, rd, `RV_OP_REG};
    endfunction

    function automatic word_t i_format(input logic [6:0] opcode, input logic [2:0] funct3,
                                       input reg_idx_t rd, input reg_idx_t rs1,
                                       input logic [11:0] imm);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic word_t s_format(input reg_idx_t rs2, input reg_idx_t rs1,
                                       input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE}; // sw
    endfunction

    function automatic word_t b_format(input reg_idx_t rs1, input reg_idx_t rs2,
                                       input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    task automatic add_expected(input word_t pc, input logic wr_en, input reg_idx_t idx,
                                input word_t data, input logic halt);
        expected[n_expected] = {pc, wr_en, idx, data, halt};
        n_expected++;
    endtask

    task automatic build_tables();
        program_words[0]  = i_format(`RV_OP_IMM, 3'b000, 5'd1, 5'd0, 12'd5);     // x1 = 5
        program_words[1]  = i_format(`RV_OP_IMM, 3'b000, 5'd2, 5'd1, 12'd7);     // from ex
        program_words[2]  = r_format(7'h00, 5'd3, 5'd1, 5'd2);                    // add
        program_words[3]  = r_format(7'h20, 5'd4, 5'd3, 5'd1);                    // sub
        program_words[4]  = i_format(`RV_OP_IMM, 3'b000, 5'd5, 5'd0, 12'h100);   // base
        program_words[5]  = s_format(5'd4, 5'd5, 12'd4);                          // sw x4, 4(x5)
        program_words[6]  = i_format(`RV_OP_LOAD, 3'b010, 5'd6, 5'd5, 12'd4);    // reads it back
        program_words[7]  = r_format(7'h00, 5'd7, 5'd6, 5'd3);                    // load-use
        program_words[8]  = i_format(`RV_OP_LOAD, 3'b010, 5'd8, 5'd5, 12'd0);    // preloaded
        program_words[9]  = i_format(`RV_OP_IMM, 3'b000, 5'd9, 5'd0, 12'd3);
        program_words[10] = r_format(7'h00, 5'd10, 5'd8, 5'd9);                   // load in mem
        program_words[11] = b_format(5'd2, 5'd4, 13'd12);                         // taken
        program_words[12] = i_format(`RV_OP_IMM, 3'b000, 5'd11, 5'd0, 12'd1);    // squashed
        program_words[13] = i_format(`RV_OP_IMM, 3'b000, 5'd12, 5'd0, 12'd2);    // squashed
        program_words[14] = b_format(5'd1, 5'd2, 13'd8);                          // not taken
        program_words[15] = i_format(`RV_OP_IMM, 3'b000, 5'd0, 5'd0, 12'd9);     // x0 target
        program_words[16] = r_format(7'h00, 5'd13, 5'd0, 5'd1);                   // x0 reads 0
        program_words[17] = `RV_WFI;

        add_expected(32'h00, 1'b1, 5'd1, 32'd5, 1'b0);
        add_expected(32'h04, 1'b1, 5'd2, 32'd12, 1'b0);
        add_expected(32'h08, 1'b1, 5'd3, 32'd17, 1'b0);
        add_expected(32'h0c, 1'b1, 5'd4, 32'd12, 1'b0);
        add_expected(32'h10, 1'b1, 5'd5, 32'h100, 1'b0);
        add_expected(32'h14, 1'b0, 5'd0, 32'd0, 1'b0);       // store
        add_expected(32'h18, 1'b1, 5'd6, 32'd12, 1'b0);
        add_expected(32'h1c, 1'b1, 5'd7, 32'd29, 1'b0);
        add_expected(32'h20, 1'b1, 5'd8, 32'h1000, 1'b0);
        add_expected(32'h24, 1'b1, 5'd9, 32'd3, 1'b0);
        add_expected(32'h28, 1'b1, 5'd10, 32'h1003, 1'b0);
        add_expected(32'h2c, 1'b0, 5'd0, 32'd0, 1'b0);       // beq jumps to 0x38
        add_expected(32'h38, 1'b0, 5'd0, 32'd0, 1'b0);
        add_expected(32'h3c, 1'b0, 5'd0, 32'd0, 1'b0);       // addi x0 writes nothing
        add_expected(32'h40, 1'b1, 5'd13, 32'd5, 1'b0);
        add_expected(32'h44, 1'b0, 5'd0, 32'd0, 1'b1);       // wfi
    endtask

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    task automatic stop_on_failure();
        $display("Some tests failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("error at %0d ns: %s", $time, msg);
        stop_on_failure();
    endtask

    // idx and data only matter when a register is written
    task automatic check_commit(input word_t pc, input logic wr_en, input reg_idx_t idx,
                                input word_t data);
        if (commit_pc !== pc || commit_wr_en !== wr_en) begin
            report_mismatch($sformatf("commit pc %h wr_en %b, expected pc %h wr_en %b",
                                      commit_pc, commit_wr_en, pc, wr_en));
        end else if (wr_en && (commit_idx !== idx || commit_data !== data)) begin
            report_mismatch($sformatf("pc %h wrote x%0d = %h, expected x%0d = %h",
                                      pc, commit_idx, commit_data, idx, data));
        end
    endtask

    task automatic check_halt(input logic expected_halt);
        if (halted !== expected_halt) begin
            report_mismatch($sformatf("halted is %b, expected %b", halted, expected_halt));
        end
    endtask

    // address and write data of a store on the bus
    task automatic compare_store(input word_t addr, input word_t wdata);
        if (mem_addr !== addr || mem_wdata !== wdata) begin
            report_mismatch($sformatf("store of %h to %h, expected %h to %h",
                                      mem_wdata, mem_addr, wdata, addr));
        end
    endtask

    task automatic verify_access_count(input string what, input int got, input int want);
        if (got != want) begin
            report_mismatch($sformatf("%0d %s accesses on the bus, expected %0d",
                                      got, what, want));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        clock      = 1'b0;
        reset      = 1'b1;
        n_expected = 0;
        next       = 0;
        cycles     = 0;
        tail       = 0;
        stores     = 0;
        data_loads = 0;
        wfi_done   = 1'b0;
        build_tables();
        i_memory.fill_pattern();
        for (int a = 0; a < PROG_LEN; a++) begin
            i_memory.write_word(4 * a, program_words[a]);
        end
        i_memory.write_word(DATA_BASE, 32'h0000_1000);
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        while (tail < TAIL) begin
            @(posedge clock); // sampled before the edge updates anything
            cycles++;
            if (cycles > MAX_CYCLES) begin
                $display("timeout: pipeline did not halt within %0d cycles", MAX_CYCLES);
                stop_on_failure();
            end
            if (!halted && mem_command == bus_store) begin
                stores++;
                compare_store(DATA_BASE + 4, 32'd12); // x4 = 17 - 5 into x5 + 4
            end
            if (!halted && mem_command == bus_load && mem_addr >= DATA_BASE) data_loads++;
            if (commit_valid) begin
                if (next >= n_expected) begin
                    report_mismatch($sformatf("unexpected commit at pc %h", commit_pc));
                end else begin
                    check_commit(expected[next].pc, expected[next].wr_en,
                                 expected[next].idx, expected[next].data);
                    if (expected[next].halt) wfi_done = 1'b1;
                    next++;
                end
            end
            check_halt(wfi_done); // rises with the wfi commit and sticks
            if (wfi_done) tail++;
        end

        verify_access_count("store", stores, 1);
        verify_access_count("data load", data_loads, 2);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
rv_pkg.sv
bypass_if.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
memory_access.sv
rv_pipeline.sv
tb_memory.sv
tb_rv_pipeline.sv
